// ==== logic/intra_macros.svh ====
`ifndef INTRA_MACROS_SVH
`define INTRA_MACROS_SVH

// Fixed quantizer setting, any value 0..51 is legal
`define INTRA_QP 27

// Pixel width
`define PIX_W 8

// Signed residual, pixel minus prediction
`define RES_W 9

// Signed quantized coefficient
`define COEF_W 15

`endif

// ==== logic/intra_pkg.sv ====
`default_nettype none
`include "intra_macros.svh"

package intra_pkg;

    typedef logic        [`PIX_W-1:0]  pix_t;
    typedef logic signed [`RES_W-1:0]  res_t;
    typedef logic signed [`COEF_W-1:0] coef_t;

    typedef struct packed {
        pix_t [0:15] pix;                     // Raster order, row 0 first
    } pix_blk_t;

    typedef struct packed {
        res_t [0:15] res;
    } res_blk_t;

    typedef struct packed {
        coef_t [0:15] coef;
    } coef_blk_t;

    typedef struct packed {
        pix_t [0:3] top;                      // Row above, left to right
        pix_t [0:3] left;                     // Column to the left, top to bottom
        logic       top_avail;
        logic       left_avail;
    } nbr_t;

    // Row is QP mod 6, column is position class
    localparam int QUANT_MF [0:5][0:2] = '{
        '{13107, 5243, 8066},
        '{11916, 4660, 7490},
        '{10082, 4194, 6554},
        '{ 9362, 3647, 5825},
        '{ 8192, 3355, 5243},
        '{ 7282, 2893, 4559}
    };

    localparam int DEQUANT_V [0:5][0:2] = '{
        '{10, 16, 13},
        '{11, 18, 14},
        '{13, 20, 16},
        '{14, 23, 18},
        '{16, 25, 20},
        '{18, 29, 23}
    };

    // 0 even-even, 1 odd-odd, 2 mixed
    function automatic int pos_class(input int idx);
        int row_odd;
        int col_odd;
        row_odd = (idx / 4) % 2;
        col_odd = idx % 2;
        if (row_odd == 0 && col_odd == 0) begin
            return 0;
        end else if (row_odd == 1 && col_odd == 1) begin
            return 1;
        end
        return 2;
    endfunction

endpackage : intra_pkg

`default_nettype wire

// ==== logic/intra_dc_predictor.sv ====
`default_nettype none
`include "intra_macros.svh"

module intra_dc_predictor (
    input  logic                clk,
    input  logic                rst,
    input  logic                blk_valid_i,
    input  intra_pkg::pix_blk_t blk_i,
    input  intra_pkg::nbr_t     nbr_i,
    output logic                res_valid_o,
    output intra_pkg::res_blk_t res_blk_o,
    output intra_pkg::pix_t     pred_dc_o
);
    import intra_pkg::*;

    localparam int SUM_W = `PIX_W + 2;        // Four pixels
    localparam int ACC_W = `PIX_W + 3;        // Eight pixels

    logic [SUM_W-1:0] top_sum;
    logic [SUM_W-1:0] left_sum;
    logic [ACC_W-1:0] all_sum;
    pix_t             dc;
    res_blk_t         res_nxt;

    always_comb begin : nbr_sum
        top_sum  = '0;
        left_sum = '0;
        for (int k = 0; k < 4; k++) begin
            top_sum  = top_sum + SUM_W'(nbr_i.top[k]);
            left_sum = left_sum + SUM_W'(nbr_i.left[k]);
        end
        all_sum = ACC_W'(top_sum) + ACC_W'(left_sum);
    end

    always_comb begin : dc_select
        unique case ({nbr_i.top_avail, nbr_i.left_avail})
            2'b11:   dc = pix_t'((all_sum + ACC_W'(4)) >> 3);
            2'b10:   dc = pix_t'((top_sum + SUM_W'(2)) >> 2);
            2'b01:   dc = pix_t'((left_sum + SUM_W'(2)) >> 2);
            default: dc = pix_t'(128);        // No neighbours
        endcase
    end

    always_comb begin : residual
        for (int i = 0; i < 16; i++) begin
            res_nxt.res[i] = $signed({1'b0, blk_i.pix[i]}) - $signed({1'b0, dc});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= blk_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid_i) begin
            res_blk_o <= res_nxt;
            pred_dc_o <= dc;                  // Kept for reconstruction
        end
    end

endmodule : intra_dc_predictor

`default_nettype wire

// ==== logic/tq_dct_quant.sv ====
`default_nettype none
`include "intra_macros.svh"

module tq_dct_quant (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 res_valid_i,
    input  intra_pkg::res_blk_t  res_blk_i,
    output logic                 coef_valid_o,
    output intra_pkg::coef_blk_t coef_blk_o
);
    import intra_pkg::*;

    localparam int ROW_W    = `RES_W + 3;     // Row gain up to 6
    localparam int COL_W    = `RES_W + 6;     // Total gain up to 36
    localparam int QBITS    = 15 + `INTRA_QP / 6;
    localparam int QP_REM   = `INTRA_QP % 6;
    localparam int Q_ROUND  = (1 << QBITS) / 3;   // Intra rounding offset
    localparam int COEF_MAX = (1 << (`COEF_W - 1)) - 1;

    typedef logic signed [COL_W-1:0] bf_t;
    typedef bf_t [0:3] quad_t;

    logic                    row_vld;
    logic signed [ROW_W-1:0] row_nxt [16];
    logic signed [ROW_W-1:0] row_q   [16];
    coef_blk_t               coef_nxt;

    function automatic quad_t fwd_bfly(input quad_t x);
        bf_t   s0;
        bf_t   s1;
        bf_t   d0;
        bf_t   d1;
        quad_t y;
        s0   = x[0] + x[3];
        s1   = x[1] + x[2];
        d0   = x[0] - x[3];
        d1   = x[1] - x[2];
        y[0] = s0 + s1;
        y[1] = (d0 <<< 1) + d1;
        y[2] = s0 - s1;
        y[3] = d0 - (d1 <<< 1);
        return y;
    endfunction

    function automatic coef_t quantize(input bf_t val, input int mf);
        logic [COL_W-1:0] mag;
        logic [31:0]      lvl;
        mag = val[COL_W-1] ? COL_W'(-val) : COL_W'(val);
        lvl = (32'(mag) * 32'(mf) + 32'(Q_ROUND)) >> QBITS;
        if (lvl > 32'(COEF_MAX)) begin
            lvl = 32'(COEF_MAX);              // Saturate magnitude
        end
        return val[COL_W-1] ? -coef_t'(lvl) : coef_t'(lvl);
    endfunction

    always_comb begin : row_fwd
        quad_t x;
        quad_t y;
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                x[k] = bf_t'(res_blk_i.res[4*r+k]);
            end
            y = fwd_bfly(x);
            for (int k = 0; k < 4; k++) begin
                row_nxt[4*r+k] = ROW_W'(y[k]);
            end
        end
    end

    always_comb begin : col_quant
        quad_t x;
        quad_t y;
        for (int c = 0; c < 4; c++) begin
            for (int k = 0; k < 4; k++) begin
                x[k] = bf_t'(row_q[4*k+c]);
            end
            y = fwd_bfly(x);
            for (int k = 0; k < 4; k++) begin
                coef_nxt.coef[4*k+c] = quantize(y[k], QUANT_MF[QP_REM][pos_class(4*k+c)]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_vld      <= 1'b0;
            coef_valid_o <= 1'b0;
        end else begin
            row_vld      <= res_valid_i;
            coef_valid_o <= row_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            row_q <= row_nxt;
        end
        if (row_vld) begin
            coef_blk_o <= coef_nxt;
        end
    end

endmodule : tq_dct_quant

`default_nettype wire

// ==== logic/tq_idct_dequant.sv ====
`default_nettype none
`include "intra_macros.svh"

module tq_idct_dequant (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 coef_valid_i,
    input  intra_pkg::coef_blk_t coef_blk_i,
    output logic                 rres_valid_o,
    output intra_pkg::res_blk_t  rres_blk_o
);
    import intra_pkg::*;

    localparam int QP_DIV  = `INTRA_QP / 6;
    localparam int QP_REM  = `INTRA_QP % 6;
    localparam int BF_W    = `COEF_W + 5 + QP_DIV + 4;   // Rescale plus two passes
    localparam int RES_MAX = (1 << (`RES_W - 1)) - 1;
    localparam int RES_MIN = -(1 << (`RES_W - 1));

    typedef logic signed [BF_W-1:0] bf_t;
    typedef bf_t [0:3] quad_t;

    logic     row_vld;
    bf_t      row_nxt [16];
    bf_t      row_q   [16];
    res_blk_t rres_nxt;

    // Odd inputs enter at half weight
    function automatic quad_t inv_bfly(input quad_t x);
        bf_t   e0;
        bf_t   e1;
        bf_t   e2;
        bf_t   e3;
        quad_t y;
        e0   = x[0] + x[2];
        e1   = x[0] - x[2];
        e2   = (x[1] >>> 1) - x[3];
        e3   = x[1] + (x[3] >>> 1);
        y[0] = e0 + e3;
        y[1] = e1 + e2;
        y[2] = e1 - e2;
        y[3] = e0 - e3;
        return y;
    endfunction

    function automatic bf_t rescale(input coef_t c, input int v);
        bf_t w;
        w = bf_t'(c) * bf_t'(v);
        return w <<< QP_DIV;
    endfunction

    function automatic res_t round_sat(input bf_t v);
        bf_t r;
        r = (v + bf_t'(32)) >>> 6;
        if (r > bf_t'(RES_MAX)) begin
            return res_t'(RES_MAX);
        end else if (r < bf_t'(RES_MIN)) begin
            return res_t'(RES_MIN);
        end
        return res_t'(r);
    endfunction

    always_comb begin : row_inv
        quad_t x;
        quad_t y;
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                x[k] = rescale(coef_blk_i.coef[4*r+k], DEQUANT_V[QP_REM][pos_class(4*r+k)]);
            end
            y = inv_bfly(x);
            for (int k = 0; k < 4; k++) begin
                row_nxt[4*r+k] = y[k];
            end
        end
    end

    always_comb begin : col_inv
        quad_t x;
        quad_t y;
        for (int c = 0; c < 4; c++) begin
            for (int k = 0; k < 4; k++) begin
                x[k] = row_q[4*k+c];
            end
            y = inv_bfly(x);
            for (int k = 0; k < 4; k++) begin
                rres_nxt.res[4*k+c] = round_sat(y[k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_vld      <= 1'b0;
            rres_valid_o <= 1'b0;
        end else begin
            row_vld      <= coef_valid_i;
            rres_valid_o <= row_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (coef_valid_i) begin
            row_q <= row_nxt;
        end
        if (row_vld) begin
            rres_blk_o <= rres_nxt;
        end
    end

endmodule : tq_idct_dequant

`default_nettype wire

// ==== logic/intra_recon.sv ====
`default_nettype none
`include "intra_macros.svh"

module intra_recon (
    input  logic                clk,
    input  logic                rst,
    input  logic                pred_valid_i,
    input  intra_pkg::pix_t     pred_dc_i,
    input  logic                rres_valid_i,
    input  intra_pkg::res_blk_t rres_blk_i,
    output logic                recon_valid_o,
    output intra_pkg::pix_blk_t recon_o
);
    import intra_pkg::*;

    localparam int SUM_W   = `PIX_W + 2;
    localparam int PIX_MAX = (1 << `PIX_W) - 1;

    pix_t       dly_dc [4];                   // Covers the transform latency
    logic [3:0] dly_vld;
    logic       load_en;
    pix_blk_t   recon_nxt;

    assign load_en = rres_valid_i & dly_vld[3];

    always_comb begin : add_clip
        logic signed [SUM_W-1:0] sum;
        for (int i = 0; i < 16; i++) begin
            sum = $signed({2'b00, dly_dc[3]}) + SUM_W'(rres_blk_i.res[i]);
            if (sum < 0) begin
                recon_nxt.pix[i] = '0;
            end else if (sum > SUM_W'(PIX_MAX)) begin
                recon_nxt.pix[i] = pix_t'(PIX_MAX);
            end else begin
                recon_nxt.pix[i] = pix_t'(sum);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dly_vld       <= '0;
            recon_valid_o <= 1'b0;
        end else begin
            dly_vld       <= {dly_vld[2:0], pred_valid_i};
            recon_valid_o <= load_en;
        end
    end

    always_ff @(posedge clk) begin
        if (pred_valid_i) begin
            dly_dc[0] <= pred_dc_i;
        end
        for (int k = 1; k < 4; k++) begin
            if (dly_vld[k-1]) begin
                dly_dc[k] <= dly_dc[k-1];
            end
        end
        if (load_en) begin
            recon_o <= recon_nxt;
        end
    end

endmodule : intra_recon

`default_nettype wire

// ==== logic/intra_4x4_pe.sv ====
`default_nettype none

module intra_4x4_pe (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 blk_valid_i,
    input  intra_pkg::pix_blk_t  blk_i,
    input  intra_pkg::nbr_t      nbr_i,
    output logic                 coef_valid_o,
    output intra_pkg::coef_blk_t coef_o,
    output logic                 recon_valid_o,
    output intra_pkg::pix_blk_t  recon_o
);
    import intra_pkg::*;

    logic      res_valid;                     // t+1
    res_blk_t  res_blk;
    pix_t      pred_dc;
    logic      coef_valid;                    // t+3
    coef_blk_t coef_blk;
    logic      rres_valid;                    // t+5
    res_blk_t  rres_blk;

    intra_dc_predictor u_intra_dc_predictor (
        .clk         (clk),
        .rst         (rst),
        .blk_valid_i (blk_valid_i),
        .blk_i       (blk_i),
        .nbr_i       (nbr_i),
        .res_valid_o (res_valid),
        .res_blk_o   (res_blk),
        .pred_dc_o   (pred_dc)
    );

    tq_dct_quant u_tq_dct_quant (
        .clk          (clk),
        .rst          (rst),
        .res_valid_i  (res_valid),
        .res_blk_i    (res_blk),
        .coef_valid_o (coef_valid),
        .coef_blk_o   (coef_blk)
    );

    tq_idct_dequant u_tq_idct_dequant (
        .clk          (clk),
        .rst          (rst),
        .coef_valid_i (coef_valid),
        .coef_blk_i   (coef_blk),
        .rres_valid_o (rres_valid),
        .rres_blk_o   (rres_blk)
    );

    intra_recon u_intra_recon (
        .clk           (clk),
        .rst           (rst),
        .pred_valid_i  (res_valid),
        .pred_dc_i     (pred_dc),
        .rres_valid_i  (rres_valid),
        .rres_blk_i    (rres_blk),
        .recon_valid_o (recon_valid_o),
        .recon_o       (recon_o)
    );

    assign coef_valid_o = coef_valid;
    assign coef_o       = coef_blk;

endmodule : intra_4x4_pe

`default_nettype wire

// ==== verif/intra_4x4_pe_checker.sv ====
`default_nettype none

module intra_4x4_pe_checker (
    input logic clk,
    input logic rst,
    input logic blk_valid_i,
    input logic res_valid_i,
    input logic coef_valid_i,
    input logic rres_valid_i,
    input logic recon_valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    coef_after_input: assert property (@(posedge clk) disable iff (rst)
        blk_valid_i |-> ##3 coef_valid_i)
        else $error("coefficient strobe missing 3 cycles after input");

    coef_has_input: assert property (@(posedge clk) disable iff (rst)
        coef_valid_i |-> $past(blk_valid_i, 3))
        else $error("coefficient strobe without input 3 cycles before");

    recon_after_input: assert property (@(posedge clk) disable iff (rst)
        blk_valid_i |-> ##6 recon_valid_i)
        else $error("reconstruction strobe missing 6 cycles after input");

    recon_has_input: assert property (@(posedge clk) disable iff (rst)
        recon_valid_i |-> $past(blk_valid_i, 6))
        else $error("reconstruction strobe without input 6 cycles before");

    // Also covers the first cycle after release
    valids_low_in_reset: assert property (@(posedge clk)
        rst |=> !res_valid_i && !coef_valid_i && !rres_valid_i && !recon_valid_i)
        else $error("valid strobe high during or right after reset");

endmodule : intra_4x4_pe_checker

`default_nettype wire

// ==== verif/intra_4x4_pe_model.svh ====
`ifndef INTRA_4X4_PE_MODEL_SVH
`define INTRA_4X4_PE_MODEL_SVH

// Forward core transform matrix, one basis vector per row
localparam int CF [4][4] = '{
    '{1,  1,  1,  1},
    '{2,  1, -1, -2},
    '{1, -1, -1,  1},
    '{1, -2,  2, -1}
};
localparam int QP_DIV = `INTRA_QP / 6;
localparam int QP_REM = `INTRA_QP % 6;

function automatic int predict_dc(input nbr_t n);
    int ts;
    int ls;
    ts = 0;
    ls = 0;
    for (int k = 0; k < 4; k++) begin
        ts += int'(n.top[k]);
        ls += int'(n.left[k]);
    end
    if (n.top_avail && n.left_avail) begin
        return (ts + ls + 4) >> 3;
    end else if (n.top_avail) begin
        return (ts + 2) >> 2;
    end else if (n.left_avail) begin
        return (ls + 2) >> 2;
    end
    return 128;
endfunction

// Scaling class from row and column parity
function automatic int coef_class(input int idx);
    int i;
    int j;
    i = idx / 4;
    j = idx % 4;
    if (i % 2 == 0 && j % 2 == 0) begin
        return 0;
    end else if (i % 2 == 1 && j % 2 == 1) begin
        return 1;
    end
    return 2;
endfunction

function automatic coef_blk_t transform_quantize(input pix_blk_t blk, input int dc);
    int        x [16];
    int        t [16];
    int        w;
    int        mag;
    int        lvl;
    int        qbits;
    coef_blk_t c;
    qbits = 15 + QP_DIV;
    for (int k = 0; k < 16; k++) begin
        x[k] = int'(blk.pix[k]) - dc;
    end
    for (int r = 0; r < 4; r++) begin                 // X times CF transposed
        for (int j = 0; j < 4; j++) begin
            t[4*r+j] = 0;
            for (int k = 0; k < 4; k++) begin
                t[4*r+j] += x[4*r+k] * CF[j][k];
            end
        end
    end
    for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
            w = 0;
            for (int k = 0; k < 4; k++) begin
                w += CF[i][k] * t[4*k+j];
            end
            mag = (w < 0) ? -w : w;
            lvl = (mag * QUANT_MF[QP_REM][coef_class(4*i+j)] + (1 << qbits) / 3) >> qbits;
            c.coef[4*i+j] = coef_t'((w < 0) ? -lvl : lvl);
        end
    end
    return c;
endfunction

// Standard inverse, odd inputs at half weight
function automatic void inverse_pass(input int a [4], output int b [4]);
    int e0;
    int e1;
    int e2;
    int e3;
    e0   = a[0] + a[2];
    e1   = a[0] - a[2];
    e2   = (a[1] >>> 1) - a[3];
    e3   = a[1] + (a[3] >>> 1);
    b[0] = e0 + e3;
    b[1] = e1 + e2;
    b[2] = e1 - e2;
    b[3] = e0 - e3;
endfunction

function automatic pix_t clip_pixel(input int v);
    if (v < 0) begin
        return 8'd0;
    end else if (v > 255) begin
        return 8'd255;
    end
    return pix_t'(v);
endfunction

function automatic pix_blk_t reconstruct_block(input coef_blk_t c, input int dc);
    int       d [16];
    int       h [16];
    int       a [4];
    int       b [4];
    pix_blk_t p;
    for (int k = 0; k < 16; k++) begin
        d[k] = int'(c.coef[k]) * DEQUANT_V[QP_REM][coef_class(k)] * (1 << QP_DIV);
    end
    for (int r = 0; r < 4; r++) begin
        for (int k = 0; k < 4; k++) begin
            a[k] = d[4*r+k];
        end
        inverse_pass(a, b);
        for (int k = 0; k < 4; k++) begin
            h[4*r+k] = b[k];
        end
    end
    for (int col = 0; col < 4; col++) begin
        for (int k = 0; k < 4; k++) begin
            a[k] = h[4*k+col];
        end
        inverse_pass(a, b);
        for (int k = 0; k < 4; k++) begin
            p.pix[4*k+col] = clip_pixel(dc + ((b[k] + 32) >>> 6));
        end
    end
    return p;
endfunction

`endif

// ==== verif/intra_4x4_pe_tb.sv ====
`default_nettype none
`include "intra_macros.svh"

module intra_4x4_pe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import intra_pkg::*;

    localparam int          NAME_W   = 8 * 12;
    localparam int          NUM_ROWS = 13;
    localparam logic [15:0] SEED     = 16'd96;

    typedef enum logic [1:0] {
        PAT_FLAT,
        PAT_RANDOM,
        PAT_EXTREME
    } pattern_e;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        pattern_e          pattern;
        pix_t              fill;              // Flat and extreme pixel value
        pix_t [0:3]        top;
        pix_t [0:3]        left;
        logic              top_avail;
        logic              left_avail;
        pix_t              exp_dc;            // Worked out by hand
        logic [3:0]        gap;               // Idle cycles after the block
    } stim_row_t;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        coef_blk_t         coef;
        pix_blk_t          recon;
    } expect_t;

    localparam stim_row_t TABLE [NUM_ROWS] = '{
        '{"dc_both", PAT_FLAT, 8'd98, '{8'd100, 8'd104, 8'd108, 8'd112},
          '{8'd96, 8'd92, 8'd88, 8'd84}, 1'b1, 1'b1, 8'd98, 4'd2},
        '{"dc_top", PAT_FLAT, 8'd26, '{8'd10, 8'd20, 8'd30, 8'd42},
          '{8'd200, 8'd200, 8'd200, 8'd200}, 1'b1, 1'b0, 8'd26, 4'd1},
        '{"dc_left", PAT_FLAT, 8'd252, '{8'd5, 8'd5, 8'd5, 8'd5},
          '{8'd250, 8'd251, 8'd252, 8'd253}, 1'b0, 1'b1, 8'd252, 4'd1},
        '{"dc_none", PAT_FLAT, 8'd128, '{8'd9, 8'd9, 8'd9, 8'd9},
          '{8'd240, 8'd240, 8'd240, 8'd240}, 1'b0, 1'b0, 8'd128, 4'd1},
        '{"rand_both", PAT_RANDOM, 8'd0, '{8'd60, 8'd70, 8'd80, 8'd90},
          '{8'd50, 8'd55, 8'd65, 8'd75}, 1'b1, 1'b1, 8'd68, 4'd0},
        '{"rand_top", PAT_RANDOM, 8'd0, '{8'd200, 8'd180, 8'd160, 8'd140},
          '{8'd1, 8'd2, 8'd3, 8'd4}, 1'b1, 1'b0, 8'd170, 4'd0},
        '{"rand_left", PAT_RANDOM, 8'd0, '{8'd99, 8'd99, 8'd99, 8'd99},
          '{8'd3, 8'd7, 8'd11, 8'd15}, 1'b0, 1'b1, 8'd9, 4'd3},
        '{"rand_none", PAT_RANDOM, 8'd0, '{8'd77, 8'd77, 8'd77, 8'd77},
          '{8'd77, 8'd77, 8'd77, 8'd77}, 1'b0, 1'b0, 8'd128, 4'd0},
        '{"max_none", PAT_EXTREME, 8'd255, '{8'd0, 8'd0, 8'd0, 8'd0},
          '{8'd0, 8'd0, 8'd0, 8'd0}, 1'b0, 1'b0, 8'd128, 4'd2},
        '{"max_left", PAT_EXTREME, 8'd255, '{8'd5, 8'd5, 8'd5, 8'd5},
          '{8'd250, 8'd251, 8'd252, 8'd253}, 1'b0, 1'b1, 8'd252, 4'd1},
        '{"zero_bright", PAT_EXTREME, 8'd0, '{8'd255, 8'd255, 8'd255, 8'd255},
          '{8'd246, 8'd246, 8'd246, 8'd246}, 1'b1, 1'b1, 8'd251, 4'd0},
        '{"b2b_first", PAT_RANDOM, 8'd0, '{8'd128, 8'd128, 8'd128, 8'd128},
          '{8'd128, 8'd128, 8'd128, 8'd128}, 1'b1, 1'b1, 8'd128, 4'd0},
        '{"b2b_second", PAT_RANDOM, 8'd0, '{8'd30, 8'd30, 8'd30, 8'd30},
          '{8'd30, 8'd30, 8'd30, 8'd30}, 1'b0, 1'b0, 8'd128, 4'd0}
    };

    function automatic int timeout_limit();
        int sum;
        sum = 50 + 6 * NUM_ROWS;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += int'(TABLE[r].gap);
        end
        return sum;
    endfunction

    localparam int TIMEOUT_CYCLES = timeout_limit();

    `include "intra_4x4_pe_model.svh"

    logic        clk;
    logic        rst;
    logic        blk_valid_i;
    pix_blk_t    blk_i;
    nbr_t        nbr_i;
    logic        coef_valid_o;
    coef_blk_t   coef_o;
    logic        recon_valid_o;
    pix_blk_t    recon_o;
    logic [15:0] lfsr = SEED;
    int          cycles;
    expect_t     coef_q [$];
    expect_t     recon_q [$];

    intra_4x4_pe u_intra_4x4_pe (
        .clk           (clk),
        .rst           (rst),
        .blk_valid_i   (blk_valid_i),
        .blk_i         (blk_i),
        .nbr_i         (nbr_i),
        .coef_valid_o  (coef_valid_o),
        .coef_o        (coef_o),
        .recon_valid_o (recon_valid_o),
        .recon_o       (recon_o)
    );

    bind intra_4x4_pe intra_4x4_pe_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .blk_valid_i   (blk_valid_i),
        .res_valid_i   (res_valid),
        .coef_valid_i  (coef_valid),
        .rres_valid_i  (rres_valid),
        .recon_valid_i (recon_valid_o)
    );

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic random_pixel(output pix_t p);
        p = '0;
        for (int b = 0; b < 8; b++) begin
            lfsr = lfsr_next(lfsr);
            p    = {p[6:0], lfsr[0]};
        end
    endtask

    task automatic build_block(input stim_row_t row, output pix_blk_t blk, output nbr_t nbr);
        pix_t p;
        for (int i = 0; i < 16; i++) begin
            if (row.pattern == PAT_RANDOM) begin
                random_pixel(p);
            end else begin
                p = row.fill;
            end
            blk.pix[i] = p;
        end
        nbr.top        = row.top;
        nbr.left       = row.left;
        nbr.top_avail  = row.top_avail;
        nbr.left_avail = row.left_avail;
    endtask

    task automatic abort_run(input string reason);
        $display("Simulation failed");
        $fatal(1, "%0s", reason);
    endtask

    task automatic compare_value(input logic [NAME_W-1:0] test, input string what,
                                 input logic [255:0] expected, input logic [255:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0s %0s: expected %0h, actual %0h", test, what, expected, actual);
            abort_run("output does not match the expected value");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : stimulus
        pix_blk_t blk;
        nbr_t     nbr;
        expect_t  entry;
        int       dc;
        rst         <= 1'b1;
        blk_valid_i <= 1'b0;
        blk_i       <= '0;
        nbr_i       <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_block(TABLE[r], blk, nbr);
            dc = predict_dc(nbr);
            compare_value(TABLE[r].name, "dc", 256'(TABLE[r].exp_dc), 256'(dc));
            entry.name  = TABLE[r].name;
            entry.coef  = transform_quantize(blk, dc);
            entry.recon = reconstruct_block(entry.coef, dc);
            @(posedge clk);
            blk_valid_i <= 1'b1;
            blk_i       <= blk;
            nbr_i       <= nbr;
            coef_q.push_back(entry);
            recon_q.push_back(entry);
            if (TABLE[r].gap != 4'd0) begin
                @(posedge clk);
                blk_valid_i <= 1'b0;
                repeat (int'(TABLE[r].gap) - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        blk_valid_i <= 1'b0;
        while (coef_q.size() != 0 || recon_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);                 // Catch stray strobes
        $display("Simulation passed");
        $finish;
    end

    always @(posedge clk) begin : monitor
        expect_t entry;
        if (!rst && coef_valid_o) begin
            if (coef_q.size() == 0) begin
                abort_run("coefficient strobe with no block outstanding");
            end else begin
                entry = coef_q.pop_front();
                compare_value(entry.name, "coef", 256'(entry.coef), 256'(coef_o));
            end
        end
        if (!rst && recon_valid_o) begin
            if (recon_q.size() == 0) begin
                abort_run("reconstruction strobe with no block outstanding");
            end else begin
                entry = recon_q.pop_front();
                compare_value(entry.name, "recon", 256'(entry.recon), 256'(recon_o));
            end
        end
    end

    always @(posedge clk) begin : watchdog
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("timeout while waiting for DUT outputs");
            end
        end
    end

endmodule : intra_4x4_pe_tb

`default_nettype wire

// ==== list.f ====
+incdir+logic
+incdir+verif
logic/intra_pkg.sv
logic/intra_dc_predictor.sv
logic/tq_dct_quant.sv
logic/tq_idct_dequant.sv
logic/intra_recon.sv
logic/intra_4x4_pe.sv
verif/intra_4x4_pe_checker.sv
verif/intra_4x4_pe_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing --assert
TOP       := intra_4x4_pe_tb
FILELIST  := list.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
